// File: tb.f
+incdir+.
qsnd_pkg.sv
qsnd_serial_front.sv
qsnd_chan_deser.sv
qsnd_frame_assembler.sv
qsnd_audio_out.sv
tb_qsnd_audio_out.sv

// File: Makefile
# Verilator flow for the QSound audio output path

VERILATOR ?= verilator
FILELIST  ?= tb.f
TB_TOP    ?= tb_qsnd_audio_out
RTL_TOP   ?= qsnd_audio_out
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
LINTFLAGS ?= -Wall
PASS_MSG  ?= Simulation passed

SIM_EXE := $(OBJ_DIR)/V$(TB_TOP)

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(LINTFLAGS) $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(OBJ_DIR)

sim: build
	@out="$$(./$(SIM_EXE))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: tb_qsnd_tasks.svh
/*
  Tasks of the audio output testbench, included in its top module.
  Relies on the model and consumer variables declared there.
  A word with other than WORD_BITS bits is modelled as malformed.
*/
`ifndef TB_QSND_TASKS_SVH
`define TB_QSND_TASKS_SVH

function automatic int rand_range(inout integer s, input int lo, input int hi);
    return lo + int'({$random(s)} % (hi - lo + 1));
endfunction

function automatic sample_t rand_word();
    return sample_t'($random(seed));
endfunction

task automatic hold_cycles(input int n);
    repeat (n) @(negedge clk);
endtask

// one 6 dB step is a halving, the sign bit fills from the top
function automatic sample_t scale_sample(input sample_t s, input int steps);
    sample_t v;
    v = s;
    for (int i = 0; i < steps; i++) begin
        v = {v[WORD_BITS-1], v[WORD_BITS-1:1]};
    end
    return v;
endfunction

task automatic check_frame(input frame_t got, input frame_t exp, input string what);
    if (got !== exp) begin
        stop_on_error($sformatf("Mismatch at %0t: %s is %h/%h, expected %h/%h",
                                $time, what, got.left, got.right, exp.left, exp.right));
    end
endtask

task automatic check_count(input cnt_t got, input cnt_t exp, input string what);
    if (got !== exp) begin
        stop_on_error($sformatf("Mismatch at %0t: %s is %0d, expected %0d",
                                $time, what, got, exp));
    end
endtask

task automatic check_atten(input atten_t got, input atten_t exp, input string what);
    if (got !== exp) begin
        stop_on_error($sformatf("Mismatch at %0t: %s is %0d, expected %0d",
                                $time, what, got, exp));
    end
endtask

task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
        stop_on_error($sformatf("Mismatch at %0t: %s is %b, expected %b",
                                $time, what, got, exp));
    end
endtask

// MSB first, a bit is taken when ock falls
task automatic send_word(input sample_t w, input int nbits);
    sample_t w_sh;
    logic    b;
    w_sh = w;
    for (int i = 0; i < nbits; i++) begin
        if (i < WORD_BITS) begin
            b    = w_sh[WORD_BITS-1];
            w_sh = w_sh << 1;
        end else begin
            b = 1'($random(seed));  // surplus bit
        end
        sdo = b;
        ock = 1'b1;
        hold_cycles(rand_range(seed, 4, 6));
        ock = 1'b0;
        hold_cycles(rand_range(seed, 4, 6));
    end
    ock = 1'b1;
    hold_cycles(rand_range(seed, 4, 6));
    cur_ok   = (nbits == WORD_BITS);
    cur_data = w;
endtask

// the left word just ended, predict what the frame rule gives
task automatic publish_left();
    frame_t f;
    int     free_credits;
    free_credits = CREDITS - sent_count + returned_count;
    if (!cur_ok || !right_pend || !right_ok) begin
        exp_err++;
    end else if (free_credits > 0) begin
        f.left  = scale_sample(cur_data, model_atten);
        f.right = scale_sample(right_data, model_atten);
        exp_q.push_back(f);
        sent_count++;
    end else begin
        exp_drop++;
    end
    right_pend = 1'b0;
endtask

// a psel edge closes the channel that was open
task automatic psel_to(input logic level);
    psel = level;
    if (!level) begin
        right_pend = 1'b1;
        right_ok   = cur_ok;
        right_data = cur_data;
    end else begin
        publish_left();
    end
    cur_ok = 1'b0;
    hold_cycles(8);  // covers the 5 cycle pin to frame latency
endtask

task automatic send_pair(input sample_t r, input int rbits, input sample_t l, input int lbits);
    send_word(r, rbits);
    psel_to(1'b0);
    send_word(l, lbits);
    psel_to(1'b1);
endtask

task automatic pulse_vol(input logic up);
    if (up) begin
        vol_up = 1'b1;
    end else begin
        vol_down = 1'b1;
    end
    hold_cycles(2);
    vol_up   = 1'b0;
    vol_down = 1'b0;
    hold_cycles(2);
    if (up && model_atten > 0) begin
        model_atten--;
    end else if (!up && model_atten < ATTEN_MAX) begin
        model_atten++;
    end
    check_atten(atten, atten_t'(model_atten), "atten");
endtask

task automatic wait_drained(input string what);
    int waited;
    waited = 0;
    while (rx_count != exp_q.size() || (!hold_credits && returned_count != rx_count)) begin
        @(negedge clk);
        waited++;
        if (waited > DRAIN_LIMIT) begin
            stop_on_error($sformatf("Timeout at %0t: %s did not complete", $time, what));
        end
    end
endtask

// pins go idle, psel_idle picks the open channel
task automatic apply_reset(input logic psel_idle);
    rst      = 1'b1;
    ock      = 1'b1;
    sdo      = 1'b0;
    psel     = psel_idle;
    vol_up   = 1'b0;
    vol_down = 1'b0;
    exp_q.delete();
    exp_err     = 0;
    exp_drop    = 0;
    sent_count  = 0;
    model_atten = 0;
    right_pend  = 1'b0;
    right_ok    = 1'b0;
    cur_ok      = 1'b0;
    hold_cycles(2);
    rst = 1'b0;
    hold_cycles(4);  // edge detect arms after the sync chain fills
endtask

`endif

// File: tb_qsnd_audio_out.sv
/*
  Testbench for the QSound audio output path.
  Drives the serial pins with random words from a fixed seed and checks
  frames, attenuation and counters against a model of the frame rules.
  The consumer returns credits after a random delay and can withhold
  them. Inputs change on the falling clock edge, outputs are read there.
*/
`timescale 1ns/1ps
`default_nettype none

module tb_qsnd_audio_out;
    import qsnd_pkg::*;

    localparam int SEED        = 17160;
    localparam int RUN_PAIRS   = 12;
    localparam int DRAIN_LIMIT = 1000;  // clk cycles per wait

    logic   clk = 1'b0;
    logic   rst;
    logic   ock;
    logic   sdo;
    logic   psel;
    logic   vol_up;
    logic   vol_down;
    logic   credit_return = 1'b0;
    frame_t frame;
    logic   frame_valid;
    atten_t atten;
    cnt_t   drop_count;
    cnt_t   err_count;

    integer seed     = SEED;
    integer ret_seed = SEED + 1;  // consumer delays

    // reference model
    frame_t  exp_q[$];
    int      exp_err;
    int      exp_drop;
    int      sent_count;    // frames predicted as delivered
    int      model_atten;
    logic    right_pend;
    logic    right_ok;
    sample_t right_data;
    logic    cur_ok;        // word collected in the current channel
    sample_t cur_data;
    logic    hold_credits;

    // consumer state
    int rx_count       = 0;
    int returned_count = 0;
    int ret_delay      = 0;

    always #20 clk = ~clk;

    qsnd_audio_out u_dut (
        .clk           (clk),
        .rst           (rst),
        .ock           (ock),
        .sdo           (sdo),
        .psel          (psel),
        .vol_up        (vol_up),
        .vol_down      (vol_down),
        .credit_return (credit_return),
        .frame         (frame),
        .frame_valid   (frame_valid),
        .atten         (atten),
        .drop_count    (drop_count),
        .err_count     (err_count)
    );

    task automatic stop_on_error(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1, "stopped at first error");
    endtask

    `include "tb_qsnd_tasks.svh"

    // downstream consumer with one buffer slot per frame
    always @(negedge clk) begin
        credit_return = 1'b0;
        if (rst) begin
            rx_count       = 0;
            returned_count = 0;
            ret_delay      = 0;
        end else begin
            if (frame_valid) begin
                if (rx_count >= exp_q.size()) begin
                    stop_on_error("frame_valid went high while no frame was expected");
                end else begin
                    check_frame(frame, exp_q[rx_count], $sformatf("frame %0d", rx_count));
                    rx_count++;
                end
            end
            if (!hold_credits && returned_count < rx_count) begin
                if (ret_delay == 0) begin
                    credit_return = 1'b1;
                    returned_count++;
                    ret_delay = rand_range(ret_seed, 0, 5);
                end else begin
                    ret_delay--;
                end
            end
        end
    end

    initial begin
        hold_credits = 1'b0;
        apply_reset(1'b1);  // psel idles high so the right channel is open

        repeat (RUN_PAIRS) send_pair(rand_word(), WORD_BITS, rand_word(), WORD_BITS);
        wait_drained("full volume frames");

        // attenuation pushed past both ends
        repeat (ATTEN_MAX + 2) pulse_vol(1'b0);
        repeat (3) send_pair(rand_word(), WORD_BITS, rand_word(), WORD_BITS);
        repeat (3) pulse_vol(1'b1);
        repeat (3) send_pair(rand_word(), WORD_BITS, rand_word(), WORD_BITS);
        repeat (ATTEN_MAX + 2) pulse_vol(1'b1);
        repeat (10) pulse_vol(rand_range(seed, 0, 1) == 1);
        repeat (3) send_pair(rand_word(), WORD_BITS, rand_word(), WORD_BITS);
        wait_drained("scaled frames");

        // short and long words
        send_pair(rand_word(), WORD_BITS - 1, rand_word(), WORD_BITS);
        send_pair(rand_word(), WORD_BITS, rand_word(), WORD_BITS + 1);
        send_pair(rand_word(), WORD_BITS + 1, rand_word(), WORD_BITS);
        send_pair(rand_word(), WORD_BITS, rand_word(), WORD_BITS - 1);
        send_pair(rand_word(), WORD_BITS, rand_word(), WORD_BITS);
        wait_drained("frame after malformed words");
        check_count(err_count, cnt_t'(exp_err), "err_count");
        check_count(drop_count, cnt_t'(exp_drop), "drop_count");

        // no credit returns so the buffer fills and the rest drop
        hold_credits = 1'b1;
        for (int i = 0; i < CREDITS + 3; i++) begin
            send_pair(rand_word(), WORD_BITS, rand_word(), WORD_BITS);
            check_count(drop_count, cnt_t'(exp_drop), "drop_count while credits withheld");
        end
        wait_drained("frames with credits withheld");
        hold_credits = 1'b0;
        wait_drained("credit returns");
        repeat (3) send_pair(rand_word(), WORD_BITS, rand_word(), WORD_BITS);
        wait_drained("frames after credit return");
        check_count(drop_count, cnt_t'(exp_drop), "drop_count");
        check_count(err_count, cnt_t'(exp_err), "err_count");

        // reset part way into a left word
        repeat (2) pulse_vol(1'b0);
        send_word(rand_word(), WORD_BITS);
        psel_to(1'b0);
        send_word(rand_word(), 7);
        apply_reset(1'b0);
        check_flag(frame_valid, 1'b0, "frame_valid after reset");
        check_atten(atten, atten_t'(0), "atten after reset");
        check_count(drop_count, cnt_t'(0), "drop_count after reset");
        check_count(err_count, cnt_t'(0), "err_count after reset");

        // left word with no right word since reset
        send_word(rand_word(), WORD_BITS);
        psel_to(1'b1);
        check_count(err_count, cnt_t'(exp_err), "err_count for lone left word");
        send_pair(rand_word(), WORD_BITS, rand_word(), WORD_BITS);
        wait_drained("first pair after reset");
        check_count(err_count, cnt_t'(exp_err), "err_count");
        check_count(drop_count, cnt_t'(exp_drop), "drop_count");

        $display("Simulation passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: qsnd_audio_out.sv
/*
  Audio output path top level.
  Serial pins in, stereo frames out under credit flow control.
  frame_valid rises 5 clk cycles after psel rises at the pins.
  Pins must hold each level for at least 4 clk cycles.
*/
`timescale 1ns/1ps
`default_nettype none

module qsnd_audio_out (
    input  logic             clk,
    input  logic             rst,
    input  logic             ock,
    input  logic             sdo,
    input  logic             psel,
    input  logic             vol_up,
    input  logic             vol_down,
    input  logic             credit_return,
    output qsnd_pkg::frame_t frame,
    output logic             frame_valid,
    output qsnd_pkg::atten_t atten,
    output qsnd_pkg::cnt_t   drop_count,
    output qsnd_pkg::cnt_t   err_count
);
    import qsnd_pkg::*;

    serial_strobe_t strobe;
    chan_word_t     left_word;
    chan_word_t     right_word;
    logic           left_valid;
    logic           right_valid;

    qsnd_serial_front u_front (
        .clk    (clk),
        .rst    (rst),
        .ock    (ock),
        .sdo    (sdo),
        .psel   (psel),
        .strobe (strobe)
    );

    qsnd_chan_deser #(.CHAN_SEL(1'b0)) u_left (
        .clk        (clk),
        .rst        (rst),
        .strobe     (strobe),
        .word       (left_word),
        .word_valid (left_valid)
    );

    qsnd_chan_deser #(.CHAN_SEL(1'b1)) u_right (
        .clk        (clk),
        .rst        (rst),
        .strobe     (strobe),
        .word       (right_word),
        .word_valid (right_valid)
    );

    qsnd_frame_assembler u_asm (
        .clk           (clk),
        .rst           (rst),
        .left_word     (left_word),
        .right_word    (right_word),
        .left_valid    (left_valid),
        .right_valid   (right_valid),
        .vol_up        (vol_up),
        .vol_down      (vol_down),
        .credit_return (credit_return),
        .frame         (frame),
        .frame_valid   (frame_valid),
        .atten         (atten),
        .drop_count    (drop_count),
        .err_count     (err_count)
    );

endmodule

`default_nettype wire

// File: qsnd_frame_assembler.sv
/*
  Frame assembler with volume and credit-based output.
  A frame is formed on each left word, with the right word received
  since the previous frame. Malformed or unpaired frames are counted
  in err_count, frames that find no credit are counted in drop_count.
  The DSP is never stalled. vol_up lowers the attenuation, vol_down
  raises it; both are levels synchronous to clk.
  credit_return must never exceed the frames delivered.
*/
`timescale 1ns/1ps
`default_nettype none

module qsnd_frame_assembler (
    input  logic                 clk,
    input  logic                 rst,
    input  qsnd_pkg::chan_word_t left_word,
    input  qsnd_pkg::chan_word_t right_word,
    input  logic                 left_valid,
    input  logic                 right_valid,
    input  logic                 vol_up,
    input  logic                 vol_down,
    input  logic                 credit_return,
    output qsnd_pkg::frame_t     frame,
    output logic                 frame_valid,
    output qsnd_pkg::atten_t     atten,
    output qsnd_pkg::cnt_t       drop_count,
    output qsnd_pkg::cnt_t       err_count
);
    import qsnd_pkg::*;

    chan_word_t right_q;      // latest right word
    logic       right_pend;   // right word seen since last frame
    credit_t    credits;
    logic       vol_up_d;
    logic       vol_down_d;
    logic       up_edge;
    logic       down_edge;
    logic       bad_frame;
    logic       send;
    logic       drop;

    assign up_edge   = vol_up & ~vol_up_d;
    assign down_edge = vol_down & ~vol_down_d;

    assign bad_frame = !left_word.ok || !right_pend || !right_q.ok;
    assign send      = left_valid && !bad_frame && (credits != '0);
    assign drop      = left_valid && !bad_frame && (credits == '0);

    always_ff @(posedge clk) begin
        if (right_valid) begin
            right_q <= right_word;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            right_pend <= 1'b0;
        end else if (right_valid) begin
            right_pend <= 1'b1;
        end else if (left_valid) begin
            right_pend <= 1'b0;   // consumed, even when discarded
        end
    end

    // volume steps, both edges together cancel
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            vol_up_d   <= 1'b0;
            vol_down_d <= 1'b0;
            atten      <= '0;
        end else begin
            vol_up_d   <= vol_up;
            vol_down_d <= vol_down;
            if (up_edge && !down_edge && atten != '0) begin
                atten <= atten - 1'b1;
            end else if (down_edge && !up_edge && atten != atten_t'(ATTEN_MAX)) begin
                atten <= atten + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            credits     <= credit_t'(CREDITS);
            frame_valid <= 1'b0;
            drop_count  <= '0;
            err_count   <= '0;
        end else begin
            frame_valid <= send;
            if (send && !credit_return) begin
                credits <= credits - 1'b1;
            end else if (credit_return && !send) begin
                credits <= credits + 1'b1;
            end
            if (drop && drop_count != '1) begin
                drop_count <= drop_count + 1'b1;
            end
            if (left_valid && bad_frame && err_count != '1) begin
                err_count <= err_count + 1'b1;
            end
        end
    end

    // scaled samples, 6 dB per shift
    always_ff @(posedge clk) begin
        if (send) begin
            frame.left  <= $signed(left_word.data) >>> atten;
            frame.right <= $signed(right_q.data) >>> atten;
        end
    end

    a_send_with_credit: assert property (
        @(posedge clk) disable iff (rst)
        frame_valid |-> $past(credits) != '0
    ) else $error("frame sent with no credit");

    // consumer returned a slot it never received
    a_credit_bound: assert property (
        @(posedge clk) disable iff (rst)
        credit_return |-> credits < credit_t'(CREDITS)
    ) else $error("credit returned above CREDITS");

endmodule

`default_nettype wire

// File: qsnd_chan_deser.sv
/*
  Deserializer for one audio channel.
  CHAN_SEL is the psel level during which this channel takes bits:
  0 collects the left word, 1 the right word. The word is published
  one cycle after the psel edge that ends the channel. A word cut
  short by reset or by a glitch is still published, with ok low.
*/
`timescale 1ns/1ps
`default_nettype none

module qsnd_chan_deser #(
    parameter bit CHAN_SEL = 1'b0
) (
    input  logic                     clk,
    input  logic                     rst,
    input  qsnd_pkg::serial_strobe_t strobe,
    output qsnd_pkg::chan_word_t     word,
    output logic                     word_valid
);
    import qsnd_pkg::*;

    sample_t  shift_q;
    bit_cnt_t bit_cnt;
    logic     in_chan;
    logic     take_bit;
    logic     chan_end;

    assign in_chan  = (strobe.psel_lvl == CHAN_SEL);
    assign take_bit = in_chan & strobe.ock_fall;
    // left ends when psel goes high, right when it goes low
    assign chan_end = CHAN_SEL ? strobe.psel_fall : strobe.psel_rise;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bit_cnt    <= '0;
            word_valid <= 1'b0;
        end else begin
            word_valid <= chan_end;
            if (chan_end) begin
                bit_cnt <= '0;
            end else if (take_bit && bit_cnt <= bit_cnt_t'(WORD_BITS)) begin
                bit_cnt <= bit_cnt + 1'b1;  // stops at WORD_BITS+1
            end
        end
    end

    // shift register, MSB arrives first
    always_ff @(posedge clk) begin
        if (take_bit) begin
            shift_q <= {shift_q[WORD_BITS-2:0], strobe.bit_val};
        end
    end

    always_ff @(posedge clk) begin
        if (chan_end) begin
            word.data <= shift_q;
            word.ok   <= (bit_cnt == bit_cnt_t'(WORD_BITS));
        end
    end

    // psel edges are at least 4 cycles apart, so a publish is one pulse
    a_single_pulse: assert property (
        @(posedge clk) disable iff (rst)
        word_valid |=> !word_valid
    ) else $error("word_valid held high for two cycles");

endmodule

`default_nettype wire

// File: qsnd_serial_front.sv
/*
  Serial front end for the DSP audio pins.
  ock, sdo and psel are asynchronous to clk and must hold each level
  for at least 4 clk cycles. Every strobe lags its pin change by
  exactly 3 clk cycles. Edges are masked for the first cycles after
  reset, until the synchronizer holds real pin values.
*/
`timescale 1ns/1ps
`default_nettype none

module qsnd_serial_front (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     ock,
    input  logic                     sdo,
    input  logic                     psel,
    output qsnd_pkg::serial_strobe_t strobe
);
    import qsnd_pkg::*;

    logic ock_s1, ock_s2, ock_d;
    logic sdo_s1, sdo_s2;
    logic psel_s1, psel_s2, psel_d;
    logic [2:0] arm;  // fills with ones once the sync chain is valid

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ock_s1  <= 1'b0;
            ock_s2  <= 1'b0;
            ock_d   <= 1'b0;
            sdo_s1  <= 1'b0;
            sdo_s2  <= 1'b0;
            psel_s1 <= 1'b0;
            psel_s2 <= 1'b0;
            psel_d  <= 1'b0;
            arm     <= '0;
            strobe  <= '0;
        end else begin
            // two-flop synchronizers
            ock_s1  <= ock;
            ock_s2  <= ock_s1;
            sdo_s1  <= sdo;
            sdo_s2  <= sdo_s1;
            psel_s1 <= psel;
            psel_s2 <= psel_s1;
            // previous synchronized values for edge compare
            ock_d   <= ock_s2;
            psel_d  <= psel_s2;
            arm     <= {arm[1:0], 1'b1};

            strobe.ock_fall  <= arm[2] & ock_d & ~ock_s2;
            strobe.bit_val   <= sdo_s2;                     // aligned with ock sample
            strobe.psel_rise <= arm[2] & ~psel_d & psel_s2;
            strobe.psel_fall <= arm[2] & psel_d & ~psel_s2;
            strobe.psel_lvl  <= psel_s2;
        end
    end

endmodule

`default_nettype wire

// File: qsnd_pkg.sv
/*
  Shared types and constants for the QSound audio output path.
  Samples are two's complement, sent MSB first on the serial link.
  Attenuation is an arithmetic shift, so each step is about 6 dB.
  CREDITS must match the depth of the downstream sample buffer.
*/
`default_nettype none

package qsnd_pkg;

    localparam int WORD_BITS = 16;  // bits per channel word
    localparam int ATTEN_MAX = 7;   // deepest attenuation step
    localparam int CREDITS   = 4;   // downstream buffer slots

    // room for WORD_BITS plus one overflow state
    localparam int BIT_CNT_W = $clog2(WORD_BITS + 2);

    typedef logic signed [WORD_BITS-1:0] sample_t;
    typedef logic [2:0]                  atten_t;   // 0 is full volume
    typedef logic [15:0]                 cnt_t;     // saturating event count
    typedef logic [2:0]                  credit_t;
    typedef logic [BIT_CNT_W-1:0]        bit_cnt_t;

    // edge strobes from the serial front end, all one clk wide
    typedef struct packed {
        logic ock_fall;
        logic bit_val;     // sdo taken with ock_fall
        logic psel_rise;
        logic psel_fall;
        logic psel_lvl;
    } serial_strobe_t;

    typedef struct packed {
        sample_t data;
        logic    ok;       // exactly WORD_BITS bits were seen
    } chan_word_t;

    typedef struct packed {
        sample_t left;
        sample_t right;
    } frame_t;

endpackage

`default_nettype wire
